/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fw_ip1
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
source/ip1_cmd_pkg.sv
source/ip1_test_pkg.sv
source/ip1_cmd_regs.sv
source/configclk_generator.sv
source/ip1_test_seq.sv
source/ip1_readout.sv
source/fw_ip1.sv
testbench/fw_ip1_checker.sv
testbench/fw_ip1_monitor.sv
testbench/tb_fw_ip1.sv

/* source/configclk_generator.sv */
// programmable configuration clock
// phase counts 0..period and wraps, clock is high in the second half
`timescale 1ns/1ns

module configclk_generator #(
  parameter int PERIOD_BITS = 7
) (
  input  logic                   fw_axi_clk,
  input  logic                   op_code_w_reset,
  input  logic                   fw_dev_id_enable,
  input  logic [PERIOD_BITS-1:0] period,
  output logic [PERIOD_BITS-1:0] phase,
  output logic                   config_clk
);

  logic [PERIOD_BITS-1:0] phase_next;

  // >= also recovers when period is lowered mid count
  assign phase_next = (phase >= period) ? '0 : phase + 1'b1;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      phase      <= '0;
      config_clk <= 1'b0;
    end else if (fw_dev_id_enable) begin  // stalls while device not selected
      phase      <= phase_next;
      config_clk <= phase_next > (period >> 1);  // registered with phase, stays aligned
    end
  end

endmodule

/* source/fw_ip1.sv */
// ip1 firmware top
// command registers, config clock, test sequencer and read mux
`timescale 1ns/1ns

module fw_ip1 #(
  parameter int ARRAY_DEPTH = 8,
  parameter int PERIOD_BITS = ip1_cmd_pkg::FAST_PERIOD_BITS
) (
  input  logic                  fw_axi_clk,
  input  logic                  op_code_w_reset,
  input  logic                  fw_dev_id_enable,
  input  ip1_cmd_pkg::op_code_t op_code,
  input  logic [23:0]           sw_write24,
  output logic [31:0]           fw_read_data32,
  output logic [31:0]           fw_read_status32,
  output logic                  fw_super_pixel_sel,
  output logic                  fw_config_clk,
  output logic                  fw_reset_not,
  output logic                  fw_config_in,
  output logic                  fw_config_load,
  input  logic                  fw_config_out
);

  logic [23:0]                  cfg_static;
  logic [ARRAY_DEPTH-1:0][15:0] cfg_array_0;
  logic [ARRAY_DEPTH-1:0][15:0] cfg_array_1;
  logic                         exec_start;
  ip1_cmd_pkg::op_code_t        rd_sel;
  logic                         test_done;
  logic                         cfg_error;
  logic [PERIOD_BITS-1:0]       phase;
  logic                         config_clk;
  logic [2*ARRAY_DEPTH*16-1:0]  readback;

  // --------------------
  ip1_cmd_regs #(.ARRAY_DEPTH(ARRAY_DEPTH)) u_cmd_regs (
    .fw_axi_clk, .op_code_w_reset, .fw_dev_id_enable, .op_code, .sw_write24,
    .test_done, .cfg_error, .cfg_static, .cfg_array_0, .cfg_array_1,
    .exec_start, .rd_sel, .status(fw_read_status32)
  );

  configclk_generator #(.PERIOD_BITS(PERIOD_BITS)) u_fast_clk (
    .fw_axi_clk, .op_code_w_reset, .fw_dev_id_enable,
    .period(cfg_static[ip1_cmd_pkg::FAST_PERIOD_LSB +: PERIOD_BITS]),
    .phase, .config_clk
  );

  ip1_test_seq #(.ARRAY_DEPTH(ARRAY_DEPTH), .PERIOD_BITS(PERIOD_BITS)) u_test_seq (
    .fw_axi_clk, .op_code_w_reset, .exec_start,
    .exec_word(sw_write24),  // latched inside on the execute edge
    .fast_period(cfg_static[ip1_cmd_pkg::FAST_PERIOD_LSB +: PERIOD_BITS]),
    .phase, .config_clk, .cfg_array_0, .cfg_array_1,
    .super_pix_sel(cfg_static[ip1_cmd_pkg::SUPER_PIX_SEL_BIT]),
    .fw_config_out, .fw_super_pixel_sel, .fw_config_clk, .fw_reset_not,
    .fw_config_in, .fw_config_load, .test_done, .cfg_error, .readback
  );

  ip1_readout #(.ARRAY_DEPTH(ARRAY_DEPTH)) u_readout (
    .rd_sel, .addr(sw_write24[23:16]), .cfg_static, .cfg_array_0, .cfg_array_1,
    .readback, .fw_read_data32
  );

endmodule

/* source/ip1_cmd_pkg.sv */
// ip1 command side definitions
// opcodes, sticky status layout and static configuration word fields
package ip1_cmd_pkg;

  // --------------------
  // software opcodes, valid only while the device id is enabled
  typedef enum logic [3:0] {
    OP_NONE           = 4'h0,
    OP_W_CFG_STATIC   = 4'h1,  // write static word from sw_write24
    OP_R_CFG_STATIC   = 4'h2,
    OP_W_CFG_ARRAY_0  = 4'h3,  // addr in 23:16, data in 15:0
    OP_R_CFG_ARRAY_0  = 4'h4,
    OP_W_CFG_ARRAY_1  = 4'h5,
    OP_R_CFG_ARRAY_1  = 4'h6,
    OP_R_DATA_ARRAY   = 4'h7,  // readback chain, one 32-bit word per addr
    OP_W_STATUS_CLEAR = 4'h8,
    OP_W_EXECUTE      = 4'h9   // rising edge starts test 1
  } op_code_t;

  // --------------------
  // status word bit positions
  localparam int ST_W_CFG   = 0;   // static word written
  localparam int ST_R_CFG   = 1;   // static word read
  localparam int ST_W_ARRAY = 2;   // any array written
  localparam int ST_R_ARRAY = 3;   // any array read
  localparam int ST_R_DATA  = 4;
  localparam int ST_EXECUTE = 5;
  localparam int ST_DONE    = 12;  // follows the sequencer, not sticky
  localparam int ST_ERROR   = 31;  // bad execute word

  // static word fields
  // fast config clock period in fw clocks, 7 bits gives up to 128
  localparam int FAST_PERIOD_LSB   = 0;
  localparam int FAST_PERIOD_BITS  = 7;
  localparam int SUPER_PIX_SEL_BIT = 7;

endpackage

/* source/ip1_cmd_regs.sv */
// ip1 command registers
// gates and decodes opcodes, holds configuration and the sticky status word
`timescale 1ns/1ns

module ip1_cmd_regs #(
  parameter int ARRAY_DEPTH = 8
) (
  input  logic                         fw_axi_clk,
  input  logic                         op_code_w_reset,
  input  logic                         fw_dev_id_enable,
  input  ip1_cmd_pkg::op_code_t        op_code,
  input  logic [23:0]                  sw_write24,
  input  logic                         test_done,
  input  logic                         cfg_error,
  output logic [23:0]                  cfg_static,
  output logic [ARRAY_DEPTH-1:0][15:0] cfg_array_0,
  output logic [ARRAY_DEPTH-1:0][15:0] cfg_array_1,
  output logic                         exec_start,
  output ip1_cmd_pkg::op_code_t        rd_sel,
  output logic [31:0]                  status
);

  localparam int AW = (ARRAY_DEPTH > 1) ? $clog2(ARRAY_DEPTH) : 1;

  ip1_cmd_pkg::op_code_t op;  // opcode seen by this device
  logic [7:0]            addr;
  logic [AW-1:0]         widx;       // word index inside one array
  logic                  addr_ok;
  logic                  exec_cmd;
  logic                  exec_cmd_q;

  assign op       = fw_dev_id_enable ? op_code : ip1_cmd_pkg::OP_NONE;
  assign addr     = sw_write24[23:16];
  assign widx     = addr[AW-1:0];
  assign addr_ok  = int'(addr) < ARRAY_DEPTH;  // upper addresses dropped
  assign rd_sel   = op;                        // reads are decoded in readout

  // --------------------
  // execute edge, one cycle while the command is held
  assign exec_cmd   = (op == ip1_cmd_pkg::OP_W_EXECUTE);
  assign exec_start = exec_cmd & ~exec_cmd_q;

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      exec_cmd_q <= 1'b0;
    end else begin
      exec_cmd_q <= exec_cmd;
    end
  end

  // configuration writes, repeat harmlessly while held
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      cfg_static  <= '0;
      cfg_array_0 <= '0;
      cfg_array_1 <= '0;
    end else begin
      case (op)
        ip1_cmd_pkg::OP_W_CFG_STATIC:  cfg_static <= sw_write24;
        ip1_cmd_pkg::OP_W_CFG_ARRAY_0: if (addr_ok) cfg_array_0[widx] <= sw_write24[15:0];
        ip1_cmd_pkg::OP_W_CFG_ARRAY_1: if (addr_ok) cfg_array_1[widx] <= sw_write24[15:0];
        default: ;
      endcase
    end
  end

  // --------------------
  // sticky status, done and error mirror the sequencer one cycle late
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || op == ip1_cmd_pkg::OP_W_STATUS_CLEAR) begin
      status <= '0;
    end else begin
      case (op)
        ip1_cmd_pkg::OP_W_CFG_STATIC:  status[ip1_cmd_pkg::ST_W_CFG]   <= 1'b1;
        ip1_cmd_pkg::OP_R_CFG_STATIC:  status[ip1_cmd_pkg::ST_R_CFG]   <= 1'b1;
        ip1_cmd_pkg::OP_W_CFG_ARRAY_0,
        ip1_cmd_pkg::OP_W_CFG_ARRAY_1: status[ip1_cmd_pkg::ST_W_ARRAY] <= 1'b1;
        ip1_cmd_pkg::OP_R_CFG_ARRAY_0,
        ip1_cmd_pkg::OP_R_CFG_ARRAY_1: status[ip1_cmd_pkg::ST_R_ARRAY] <= 1'b1;
        ip1_cmd_pkg::OP_R_DATA_ARRAY:  status[ip1_cmd_pkg::ST_R_DATA]  <= 1'b1;
        ip1_cmd_pkg::OP_W_EXECUTE:     status[ip1_cmd_pkg::ST_EXECUTE] <= 1'b1;
        default: ;
      endcase
      status[ip1_cmd_pkg::ST_DONE]  <= test_done;
      status[ip1_cmd_pkg::ST_ERROR] <= cfg_error;
    end
  end

endmodule

/* source/ip1_readout.sv */
// ip1 software read mux
// static word, array word pairs and readback chain words, all combinational
`timescale 1ns/1ns

module ip1_readout #(
  parameter int ARRAY_DEPTH = 8
) (
  input  ip1_cmd_pkg::op_code_t        rd_sel,
  input  logic [7:0]                   addr,
  input  logic [23:0]                  cfg_static,
  input  logic [ARRAY_DEPTH-1:0][15:0] cfg_array_0,
  input  logic [ARRAY_DEPTH-1:0][15:0] cfg_array_1,
  input  logic [2*ARRAY_DEPTH*16-1:0]  readback,
  output logic [31:0]                  fw_read_data32
);

  localparam int DATA_WORDS = ARRAY_DEPTH;  // two 16-bit arrays fill depth 32-bit words

  // one array word, zero past the last address
  function automatic logic [15:0] array_word(input logic [ARRAY_DEPTH-1:0][15:0] arr,
                                             input int idx);
    logic [15:0] w;
    w = '0;
    if (idx < ARRAY_DEPTH) w = arr[idx];
    return w;
  endfunction

  always_comb begin
    fw_read_data32 = '0;
    case (rd_sel)
      ip1_cmd_pkg::OP_R_CFG_STATIC:  fw_read_data32 = {8'h00, cfg_static};
      ip1_cmd_pkg::OP_R_CFG_ARRAY_0: fw_read_data32 = {array_word(cfg_array_0, int'(addr) + 1),
                                                       array_word(cfg_array_0, int'(addr))};
      ip1_cmd_pkg::OP_R_CFG_ARRAY_1: fw_read_data32 = {array_word(cfg_array_1, int'(addr) + 1),
                                                       array_word(cfg_array_1, int'(addr))};
      ip1_cmd_pkg::OP_R_DATA_ARRAY: begin
        if (int'(addr) < DATA_WORDS) fw_read_data32 = readback[int'(addr)*32 +: 32];
      end
      default: ;  // writes and no-op read 0
    endcase
  end

endmodule

/* source/ip1_test_pkg.sv */
// ip1 test sequencer definitions
// FSM states and the execute word layout
package ip1_test_pkg;

  // test 1 sequencer states
  typedef enum logic [2:0] {
    IDLE      = 3'd0,  // no test run since reset
    DELAY     = 3'd1,  // wait for the delay phase
    RESET_NOT = 3'd2,  // one config clock period of asic reset
    SHIFT     = 3'd3,  // chain moving out on config_in
    DONE      = 3'd4
  } test_state_t;

  // --------------------
  // execute word fields, delay and sample share the clock period width
  localparam int DELAY_LSB          = 0;
  localparam int SAMPLE_LSB         = DELAY_LSB + ip1_cmd_pkg::FAST_PERIOD_BITS;
  localparam int LOOPBACK_BIT       = 18;  // capture config_in instead of config_out
  localparam int MASK_RESET_NOT_BIT = 23;  // keep reset_not high

  // smallest delay the sequencer accepts
  localparam int MIN_TEST_DELAY = 3;

endpackage

/* source/ip1_test_seq.sv */
// ip1 test 1 sequencer
// shifts the configuration chain out to the asic and captures the returning bits
`timescale 1ns/1ns

module ip1_test_seq #(
  parameter int ARRAY_DEPTH = 8,
  parameter int PERIOD_BITS = 7
) (
  input  logic                          fw_axi_clk,
  input  logic                          op_code_w_reset,
  input  logic                          exec_start,
  input  logic [23:0]                   exec_word,
  input  logic [PERIOD_BITS-1:0]        fast_period,
  input  logic [PERIOD_BITS-1:0]        phase,
  input  logic                          config_clk,
  input  logic [ARRAY_DEPTH-1:0][15:0]  cfg_array_0,
  input  logic [ARRAY_DEPTH-1:0][15:0]  cfg_array_1,
  input  logic                          super_pix_sel,
  input  logic                          fw_config_out,
  output logic                          fw_super_pixel_sel,
  output logic                          fw_config_clk,
  output logic                          fw_reset_not,
  output logic                          fw_config_in,
  output logic                          fw_config_load,
  output logic                          test_done,
  output logic                          cfg_error,
  output logic [2*ARRAY_DEPTH*16-1:0]   readback
);

  localparam int CHAIN_BITS = 2 * ARRAY_DEPTH * 16;
  localparam int CNT_BITS   = $clog2(CHAIN_BITS);

  ip1_test_pkg::test_state_t state;
  logic [23:0]               exec_q;   // execute word, held for the whole test
  logic [CHAIN_BITS-1:0]     chain;    // bit 0 drives config_in
  logic [CNT_BITS-1:0]       bit_cnt;
  logic [PERIOD_BITS-1:0]    delay_in;
  logic [PERIOD_BITS-1:0]    test_delay;
  logic [PERIOD_BITS-1:0]    test_sample;
  logic                      loopback;
  logic                      mask_reset_not;
  logic                      bad_cfg;
  logic                      start_ok;
  logic                      running;
  logic                      at_delay;
  logic                      at_sample;
  logic                      capture_bit;

  // --------------------
  // execute word fields
  assign delay_in       = exec_word[ip1_test_pkg::DELAY_LSB +: PERIOD_BITS];
  assign test_delay     = exec_q[ip1_test_pkg::DELAY_LSB +: PERIOD_BITS];
  assign test_sample    = exec_q[ip1_test_pkg::SAMPLE_LSB +: PERIOD_BITS];
  assign loopback       = exec_q[ip1_test_pkg::LOOPBACK_BIT];
  assign mask_reset_not = exec_q[ip1_test_pkg::MASK_RESET_NOT_BIT];

  // delay must land inside one config clock period
  assign bad_cfg = (delay_in < PERIOD_BITS'(ip1_test_pkg::MIN_TEST_DELAY)) ||
                   (delay_in > fast_period);

  // a new execute is only taken when no test is running
  assign start_ok  = exec_start &&
                     (state == ip1_test_pkg::IDLE || state == ip1_test_pkg::DONE);
  assign running   = (state != ip1_test_pkg::IDLE);
  assign at_delay  = (phase == test_delay);   // once per period
  assign at_sample = (phase == test_sample);
  assign test_done = (state == ip1_test_pkg::DONE);

  // --------------------
  // FSM
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= ip1_test_pkg::IDLE;
      bit_cnt   <= '0;
      cfg_error <= 1'b0;
    end else begin
      case (state)
        ip1_test_pkg::IDLE,
        ip1_test_pkg::DONE: begin
          if (start_ok) begin
            cfg_error <= bad_cfg;
            bit_cnt   <= '0;
            // an invalid word ends at once, otherwise the delay match could never come
            state     <= bad_cfg ? ip1_test_pkg::DONE : ip1_test_pkg::DELAY;
          end
        end
        ip1_test_pkg::DELAY:     if (at_delay) state <= ip1_test_pkg::RESET_NOT;
        ip1_test_pkg::RESET_NOT: if (at_delay) state <= ip1_test_pkg::SHIFT;  // one full period
        ip1_test_pkg::SHIFT: begin
          if (at_delay) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_BITS'(CHAIN_BITS - 1)) state <= ip1_test_pkg::DONE;
          end
        end
        default: state <= ip1_test_pkg::IDLE;
      endcase
    end
  end

  // chain out and readback in
  assign capture_bit = loopback ? fw_config_in : fw_config_out;

  always_ff @(posedge fw_axi_clk) begin
    if (start_ok) begin
      exec_q <= exec_word;
      chain  <= {cfg_array_1, cfg_array_0};  // array 0 goes out first
    end else if (state == ip1_test_pkg::SHIFT && at_delay) begin
      chain  <= {1'b0, chain[CHAIN_BITS-1:1]};
    end
    if (state == ip1_test_pkg::SHIFT && at_sample) begin
      readback <= {capture_bit, readback[CHAIN_BITS-1:1]};  // first bit ends at bit 0
    end
  end

  // --------------------
  // asic pins, all low until a test has been started
  always_comb begin
    fw_super_pixel_sel = running & super_pix_sel;
    fw_config_clk      = running & config_clk;
    fw_config_load     = running && (state != ip1_test_pkg::SHIFT);  // low = shift mode
    fw_reset_not       = running && !(state == ip1_test_pkg::RESET_NOT && !mask_reset_not);
    fw_config_in       = (state == ip1_test_pkg::SHIFT) & chain[0];
  end

endmodule

/* testbench/fw_ip1_checker.sv */
// ip1 firmware assertions
// pin levels in reset, shift mode on config_load, reset_not masking
`timescale 1ns/1ns

module fw_ip1_checker #(
  parameter int CNT_BITS = 8
) (
  input logic                      fw_axi_clk,
  input logic                      op_code_w_reset,
  input logic                      fw_super_pixel_sel,
  input logic                      fw_config_clk,
  input logic                      fw_reset_not,
  input logic                      fw_config_in,
  input logic                      fw_config_load,
  input ip1_test_pkg::test_state_t seq_state,
  input logic [CNT_BITS-1:0]       shift_cnt,
  input logic                      mask_reset_not
);

  int fails = 0;  // read by the testbench at the end

  // --------------------
  a_reset_pins: assert property (@(posedge fw_axi_clk)
    op_code_w_reset |=> !(fw_super_pixel_sel | fw_config_clk | fw_reset_not |
                          fw_config_in | fw_config_load))
    else begin
      $error("asic pins not low after reset");
      fails++;
    end

  // the chain only advances in a cycle where load was low
  a_load_shift: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    (shift_cnt != $past(shift_cnt)) |-> $past(fw_config_load == 1'b0))
    else begin
      $error("chain advanced with config_load high");
      fails++;
    end

  a_mask_reset_not: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    (mask_reset_not && seq_state != ip1_test_pkg::IDLE) |-> fw_reset_not)
    else begin
      $error("reset_not dropped with the mask bit set");
      fails++;
    end

endmodule

bind fw_ip1 fw_ip1_checker #(.CNT_BITS($clog2(2 * ARRAY_DEPTH * 16))) u_checker (
  .fw_axi_clk,
  .op_code_w_reset,
  .fw_super_pixel_sel,
  .fw_config_clk,
  .fw_reset_not,
  .fw_config_in,
  .fw_config_load,
  .seq_state(u_test_seq.state),
  .shift_cnt(u_test_seq.bit_cnt),
  .mask_reset_not(u_test_seq.mask_reset_not)
);

/* testbench/fw_ip1_monitor.sv */
// ip1 firmware monitor
// compares read data, status and asic pins with the testbench model
`timescale 1ns/1ns

module fw_ip1_monitor #(
  parameter int CHAIN_BITS = 256
) (
  input  logic        fw_axi_clk,
  input  logic        chk_read,
  input  logic [31:0] exp_read,
  input  logic [31:0] fw_read_data32,
  input  logic        chk_status,
  input  logic [31:0] exp_status,
  input  logic [31:0] status_mask,
  input  logic [31:0] fw_read_status32,
  input  logic        chk_pins,
  input  logic        exp_sps,
  input  logic        exp_mask,
  input  logic        fw_super_pixel_sel,
  input  logic        fw_reset_not,
  input  logic        fw_config_clk,
  input  logic        fw_config_load,
  output int          errors,
  output int          checks
);

  int   err_cnt   = 0;
  int   chk_cnt   = 0;
  int   clk_edges = 0;     // config_clk rising edges while load is low
  logic clk_q     = 1'b0;
  logic in_shift  = 1'b0;

  assign errors = err_cnt;
  assign checks = chk_cnt;

  // sampled on the rising edge, half a clock after the stimulus
  always @(posedge fw_axi_clk) begin
    if (chk_read) begin
      chk_cnt++;
      if (fw_read_data32 !== exp_read) begin
        err_cnt++;
        $display("ERR %0t ns: read data %08h, expected %08h", $time, fw_read_data32, exp_read);
      end
    end
    if (chk_status) begin
      chk_cnt++;
      if ((fw_read_status32 & status_mask) !== (exp_status & status_mask)) begin
        err_cnt++;
        $display("ERR %0t ns: status %08h, expected %08h under mask %08h",
                 $time, fw_read_status32, exp_status, status_mask);
      end
    end
    if (chk_pins) begin  // only while a test runs
      chk_cnt++;
      if (fw_super_pixel_sel !== exp_sps) begin
        err_cnt++;
        $display("ERR %0t ns: super_pixel_sel %b, expected %b", $time, fw_super_pixel_sel,
                 exp_sps);
      end
      if (exp_mask && fw_reset_not !== 1'b1) begin
        err_cnt++;
        $display("ERR %0t ns: reset_not dropped while masked", $time);
      end
      // one config clock per chain bit while load is low
      if (fw_config_load === 1'b0) begin
        in_shift = 1'b1;
        if (fw_config_clk === 1'b1 && clk_q === 1'b0) clk_edges++;
      end else if (in_shift) begin
        chk_cnt++;
        if (clk_edges != CHAIN_BITS) begin
          err_cnt++;
          $display("ERR %0t ns: %0d config clocks in shift, expected %0d",
                   $time, clk_edges, CHAIN_BITS);
        end
        in_shift  = 1'b0;
        clk_edges = 0;
      end
    end
    clk_q = fw_config_clk;
  end

endmodule

/* testbench/tb_fw_ip1.sv */
// ip1 firmware testbench
// random configuration and test 1 runs, compared with a local model of the firmware
`timescale 1ns/1ns

module tb_fw_ip1;

  localparam int ARRAY_DEPTH = 8;
  localparam int TIMEOUT     = 10000;  // fw clocks allowed for one test run

  logic                  fw_axi_clk;
  logic                  op_code_w_reset;
  logic                  fw_dev_id_enable;
  ip1_cmd_pkg::op_code_t op_code;
  logic [23:0]           sw_write24;
  logic [31:0]           fw_read_data32;
  logic [31:0]           fw_read_status32;
  logic                  fw_super_pixel_sel;
  logic                  fw_config_clk;
  logic                  fw_reset_not;
  logic                  fw_config_in;
  logic                  fw_config_load;
  logic                  fw_config_out;

  // monitor controls, set on the falling edge
  logic        chk_read;
  logic        chk_status;
  logic        chk_pins;
  logic [31:0] exp_read;
  logic [31:0] exp_status;
  logic [31:0] status_mask;
  logic        exp_sps;
  logic        exp_mask;
  int          errors;
  int          checks;
  int          timeouts;

  // --------------------
  // firmware model
  logic [23:0] m_static;
  logic [15:0] m_arr0 [ARRAY_DEPTH];
  logic [15:0] m_arr1 [ARRAY_DEPTH];
  logic [31:0] m_rb [ARRAY_DEPTH];  // expected readback words
  logic [31:0] m_status;
  logic [31:0] rng = 32'h9bc7afbb;

  fw_ip1 #(.ARRAY_DEPTH(ARRAY_DEPTH)) DUT (.*);

  fw_ip1_monitor #(.CHAIN_BITS(2 * ARRAY_DEPTH * 16)) u_monitor (.*);

  initial begin
    fw_axi_clk = 1'b0;
    forever #2 fw_axi_clk = ~fw_axi_clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // sticky bit that a command sets
  function automatic logic [31:0] seen_bit(input ip1_cmd_pkg::op_code_t op);
    logic [31:0] b;
    b = 32'h0;
    case (op)
      ip1_cmd_pkg::OP_W_CFG_STATIC:  b[ip1_cmd_pkg::ST_W_CFG] = 1'b1;
      ip1_cmd_pkg::OP_R_CFG_STATIC:  b[ip1_cmd_pkg::ST_R_CFG] = 1'b1;
      ip1_cmd_pkg::OP_W_CFG_ARRAY_0,
      ip1_cmd_pkg::OP_W_CFG_ARRAY_1: b[ip1_cmd_pkg::ST_W_ARRAY] = 1'b1;
      ip1_cmd_pkg::OP_R_CFG_ARRAY_0,
      ip1_cmd_pkg::OP_R_CFG_ARRAY_1: b[ip1_cmd_pkg::ST_R_ARRAY] = 1'b1;
      ip1_cmd_pkg::OP_R_DATA_ARRAY:  b[ip1_cmd_pkg::ST_R_DATA] = 1'b1;
      ip1_cmd_pkg::OP_W_EXECUTE:     b[ip1_cmd_pkg::ST_EXECUTE] = 1'b1;
      default: ;
    endcase
    return b;
  endfunction

  function automatic logic [15:0] arr_word(input logic which, input int idx);
    if (idx >= ARRAY_DEPTH) return 16'h0;  // past the last word
    return which ? m_arr1[idx] : m_arr0[idx];
  endfunction

  // chain is array 0 then array 1, 16-bit words in order
  function automatic logic [15:0] chain_half(input int i);
    return (i < ARRAY_DEPTH) ? arr_word(1'b0, i) : arr_word(1'b1, i - ARRAY_DEPTH);
  endfunction

  function automatic logic [31:0] expected_read(input ip1_cmd_pkg::op_code_t op, input int a);
    case (op)
      ip1_cmd_pkg::OP_R_CFG_STATIC:  return {8'h00, m_static};
      ip1_cmd_pkg::OP_R_CFG_ARRAY_0: return {arr_word(1'b0, a + 1), arr_word(1'b0, a)};
      ip1_cmd_pkg::OP_R_CFG_ARRAY_1: return {arr_word(1'b1, a + 1), arr_word(1'b1, a)};
      ip1_cmd_pkg::OP_R_DATA_ARRAY:  return (a < ARRAY_DEPTH) ? m_rb[a] : 32'h0;
      default:                       return 32'h0;
    endcase
  endfunction

  // --------------------
  // one command cycle, driven on the falling edge
  task automatic send(input ip1_cmd_pkg::op_code_t op, input logic [23:0] word);
    @(negedge fw_axi_clk);
    op_code    = op;
    sw_write24 = word;
    chk_read   = 1'b0;
    chk_status = 1'b0;
    if (fw_dev_id_enable) begin
      if (op == ip1_cmd_pkg::OP_W_STATUS_CLEAR) m_status = 32'h0;
      else m_status = m_status | seen_bit(op);
    end
  endtask

  task automatic write_static(input logic [23:0] word);
    send(ip1_cmd_pkg::OP_W_CFG_STATIC, word);
    m_static = word;
  endtask

  task automatic write_array(input logic which, input int a, input logic [15:0] data);
    send(which ? ip1_cmd_pkg::OP_W_CFG_ARRAY_1 : ip1_cmd_pkg::OP_W_CFG_ARRAY_0,
         {8'(a), data});
    if (a < ARRAY_DEPTH && which) m_arr1[a] = data;
    else if (a < ARRAY_DEPTH) m_arr0[a] = data;  // upper addresses are dropped
  endtask

  task automatic read_check(input ip1_cmd_pkg::op_code_t op, input int a);
    logic [31:0] r;
    r = next_rand();
    send(op, {8'(a), r[15:0]});  // low bits are noise for reads
    exp_read = expected_read(op, a);
    chk_read = 1'b1;
  endtask

  task automatic status_check(input logic [31:0] mask, input logic [31:0] expected);
    send(ip1_cmd_pkg::OP_NONE, 24'h0);
    exp_status  = expected;
    status_mask = mask;
    chk_status  = 1'b1;
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, DUT.u_checker.fails, timeouts);
    if (errors == 0 && timeouts == 0 && DUT.u_checker.fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // small period keeps a 256 bit run short
  task automatic load_config();
    logic [31:0] r;
    r = next_rand();
    write_static({r[23:8], r[7], 7'(4 + int'(r[31:24] % 8'd5))});
    for (int i = 0; i < ARRAY_DEPTH; i++) begin
      r = next_rand();
      write_array(1'b0, i, r[15:0]);
      write_array(1'b1, i, r[31:16]);
    end
  endtask

  // --------------------
  // one test 1 run, then status and readback checks
  task automatic run_test(input logic loopback, input logic mask, input logic bad);
    logic [31:0] r;
    logic [31:0] st;
    int          p;
    int          d;
    int          s;
    int          n;
    r = next_rand();
    p = int'(m_static[6:0]);
    if (!bad) d = 3 + int'(r % 32'(p - 2));   // 3 .. period
    else if (r[8]) d = int'(r % 32'd3);        // below the minimum
    else d = p + 1 + int'(r[11:10]);           // beyond the period
    s = int'(r[31:16] % 16'(p + 1));
    fw_config_out = r[20];
    send(ip1_cmd_pkg::OP_W_EXECUTE, {mask, 4'h0, loopback, 4'h0, 7'(s), 7'(d)});
    exp_sps  = m_static[ip1_cmd_pkg::SUPER_PIX_SEL_BIT];
    exp_mask = mask;
    send(ip1_cmd_pkg::OP_NONE, 24'h0);
    chk_pins = 1'b1;
    send(ip1_cmd_pkg::OP_NONE, 24'h0);  // status done is now fresh
    n = 0;
    while (fw_read_status32[ip1_cmd_pkg::ST_DONE] !== 1'b1 && n < TIMEOUT) begin
      send(ip1_cmd_pkg::OP_NONE, 24'h0);
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("timeout: test 1 did not report done within %0d clocks", TIMEOUT);
      timeouts++;
      finish_run();
    end
    chk_pins = 1'b0;
    st = 32'h0;
    st[ip1_cmd_pkg::ST_DONE]  = 1'b1;
    st[ip1_cmd_pkg::ST_ERROR] = bad;
    status_check((32'h1 << ip1_cmd_pkg::ST_DONE) | (32'h1 << ip1_cmd_pkg::ST_ERROR), st);
    if (!bad) begin
      for (int a = 0; a < ARRAY_DEPTH; a++) begin
        m_rb[a] = loopback ? {chain_half(2 * a + 1), chain_half(2 * a)} : {32{r[20]}};
      end
    end
    for (int a = 0; a < ARRAY_DEPTH + 2; a++) read_check(ip1_cmd_pkg::OP_R_DATA_ARRAY, a);
    read_check(ip1_cmd_pkg::OP_R_DATA_ARRAY, int'(r[15:8]) | 128);
  endtask

  // --------------------
  initial begin
    logic [31:0] r;
    int          a;
    op_code_w_reset  = 1'b1;
    fw_dev_id_enable = 1'b0;
    op_code          = ip1_cmd_pkg::OP_NONE;
    sw_write24       = 24'h0;
    fw_config_out    = 1'b0;
    chk_read         = 1'b0;
    chk_status       = 1'b0;
    chk_pins         = 1'b0;
    exp_read         = 32'h0;
    exp_status       = 32'h0;
    status_mask      = 32'h0;
    exp_sps          = 1'b0;
    exp_mask         = 1'b0;
    timeouts         = 0;
    m_static         = 24'h0;
    m_status         = 32'h0;
    foreach (m_arr0[i]) begin
      m_arr0[i] = 16'h0;
      m_arr1[i] = 16'h0;
      m_rb[i]   = 32'h0;
    end
    repeat (16) @(negedge fw_axi_clk);
    op_code_w_reset  = 1'b0;
    fw_dev_id_enable = 1'b1;
    status_check(32'hffff_ffff, 32'h0);

    // random writes, some addresses beyond the array depth
    r = next_rand();
    write_static(r[23:0]);
    repeat (40) begin
      r = next_rand();
      a = r[31] ? int'(r[23:16]) : int'(r[19:16] % 4'(ARRAY_DEPTH + 2));
      write_array(r[30], a, r[15:0]);
    end
    read_check(ip1_cmd_pkg::OP_R_CFG_STATIC, 0);
    for (int i = 0; i < ARRAY_DEPTH + 2; i++) begin
      read_check(ip1_cmd_pkg::OP_R_CFG_ARRAY_0, i);
      read_check(ip1_cmd_pkg::OP_R_CFG_ARRAY_1, i);
    end
    read_check(ip1_cmd_pkg::OP_R_CFG_ARRAY_1, 200);
    status_check(32'hffff_ffff, m_status);

    // commands without the device id change nothing
    fw_dev_id_enable = 1'b0;
    r = next_rand();
    send(ip1_cmd_pkg::OP_W_CFG_STATIC, r[23:0]);
    send(ip1_cmd_pkg::OP_W_CFG_ARRAY_0, {8'h00, r[31:16]});
    send(ip1_cmd_pkg::OP_W_STATUS_CLEAR, 24'h0);
    send(ip1_cmd_pkg::OP_W_EXECUTE, 24'h0);
    send(ip1_cmd_pkg::OP_NONE, 24'h0);
    fw_dev_id_enable = 1'b1;
    status_check(32'hffff_ffff, m_status);
    read_check(ip1_cmd_pkg::OP_R_CFG_STATIC, 0);
    read_check(ip1_cmd_pkg::OP_R_CFG_ARRAY_0, 0);
    send(ip1_cmd_pkg::OP_W_STATUS_CLEAR, 24'h0);
    status_check(32'hffff_ffff, 32'h0);

    // test 1 runs
    load_config();
    run_test(1'b1, 1'b0, 1'b0);  // loopback
    run_test(1'b0, 1'b0, 1'b0);  // constant config_out
    r = next_rand();
    run_test(r[0], 1'b0, 1'b1);  // bad delay
    load_config();
    run_test(1'b1, 1'b1, 1'b0);  // reset_not masked
    run_test(1'b0, 1'b1, 1'b0);
    finish_run();
  end

endmodule
